// ==== lsu.f ====
lsu_cfg_pkg.sv
lsu_types_pkg.sv
lsu_id.sv
lsu_ex.sv
lsu_lq.sv
lsu_sq.sv
lsu.sv
tb_lsu.sv

// ==== lsu.sv ====
// ###################################################################
// Load/store unit top: decode and execute stages, load queue
// and store queue
// ###################################################################
`timescale 1ns/1ps

module lsu (
    input  logic                    clk,
    input  logic                    n_rst,
    input  logic                    i_flush,
    input  logic                    i_fu_valid,
    input  lsu_types_pkg::data_t    i_fu_insn,
    input  lsu_types_pkg::data_t    i_fu_src_a,
    input  lsu_types_pkg::data_t    i_fu_src_b,
    input  lsu_types_pkg::tag_t     i_fu_tag,
    output logic                    o_fu_stall,
    output logic                    o_cdb_en,
    output lsu_types_pkg::tag_t     o_cdb_tag,
    output lsu_types_pkg::data_t    o_cdb_data,
    input  lsu_types_pkg::tag_t     i_rob_retire_tag,
    input  logic                    i_rob_retire_lq_en,
    input  logic                    i_rob_retire_sq_en,
    output logic                    o_rob_retire_stall,
    output logic                    o_rob_retire_mis_speculated,
    input  lsu_types_pkg::data_t    i_dc_rdata,
    output logic                    o_dc_re,
    output lsu_types_pkg::addr_t    o_dc_raddr,
    input  logic                    i_sq_retire_dc_hit,
    input  logic                    i_sq_retire_msq_full,
    output logic                    o_sq_retire_en,
    output lsu_types_pkg::byte_en_t o_sq_retire_byte_en,
    output lsu_types_pkg::addr_t    o_sq_retire_addr,
    output lsu_types_pkg::data_t    o_sq_retire_data
);

    lsu_types_pkg::lsu_op_t   id_op;
    lsu_types_pkg::lsu_op_t   id_q;
    lsu_types_pkg::cdb_t      ex_cdb;
    lsu_types_pkg::cdb_t      ex_q;
    logic                     lq_alloc_en;
    logic                     sq_alloc_en;
    lsu_types_pkg::sq_alloc_t sq_alloc;
    logic                     lq_full;
    logic                     sq_full;

    // Stall on either queue full, whatever the opcode
    assign o_fu_stall = lq_full || sq_full;

    assign o_cdb_en   = ex_q.valid;
    assign o_cdb_tag  = ex_q.tag;
    assign o_cdb_data = ex_q.data;

    // Decode to execute register
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            id_q <= '0;
        end else if (i_flush || o_fu_stall) begin
            id_q.valid <= 1'b0;
        end else begin
            id_q <= id_op;
        end
    end

    // Execute to CDB register
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ex_q <= '0;
        end else if (i_flush) begin
            ex_q.valid <= 1'b0;
        end else begin
            ex_q <= ex_cdb;
        end
    end

    lsu_id u_id (
        .i_valid       (i_fu_valid),
        .i_insn        (i_fu_insn),
        .i_src_a       (i_fu_src_a),
        .i_src_b       (i_fu_src_b),
        .i_tag         (i_fu_tag),
        .o_op          (id_op),
        .o_lq_alloc_en (lq_alloc_en),
        .o_sq_alloc_en (sq_alloc_en),
        .o_sq_alloc    (sq_alloc)
    );

    lsu_ex u_ex (
        .i_op       (id_q),
        .i_dc_rdata (i_dc_rdata),
        .o_dc_re    (o_dc_re),
        .o_dc_raddr (o_dc_raddr),
        .o_cdb      (ex_cdb)
    );

    lsu_lq u_lq (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .i_alloc_en       (lq_alloc_en && !o_fu_stall),
        .i_alloc_addr     (id_op.addr),
        .i_alloc_tag      (id_op.tag),
        .i_st_en          (o_sq_retire_en && !o_rob_retire_stall),
        .i_st_addr        (o_sq_retire_addr),
        .i_retire_en      (i_rob_retire_lq_en),
        .i_retire_tag     (i_rob_retire_tag),
        .o_mis_speculated (o_rob_retire_mis_speculated),
        .o_full           (lq_full)
    );

    lsu_sq u_sq (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_alloc_en     (sq_alloc_en && !o_fu_stall),
        .i_alloc        (sq_alloc),
        .i_retire_en    (i_rob_retire_sq_en),
        .i_retire_tag   (i_rob_retire_tag),
        .i_dc_hit       (i_sq_retire_dc_hit),
        .i_msq_full     (i_sq_retire_msq_full),
        .o_wr_en        (o_sq_retire_en),
        .o_wr_addr      (o_sq_retire_addr),
        .o_wr_byte_en   (o_sq_retire_byte_en),
        .o_wr_data      (o_sq_retire_data),
        .o_retire_stall (o_rob_retire_stall),
        .o_full         (sq_full)
    );

endmodule

// ==== lsu_cfg_pkg.sv ====
// ###################################################################
// LSU configuration: data path widths and queue depths
// ###################################################################
package lsu_cfg_pkg;

    // Data path and address width
    localparam int XLEN = 32;

    // ROB tag width
    localparam int TAG_W = 6;

    // Queue depths
    localparam int LQ_DEPTH = 4;
    localparam int SQ_DEPTH = 4;

    // Store queue pointer width
    localparam int SQ_PTR_W = $clog2(SQ_DEPTH);

endpackage

// ==== lsu_ex.sv ====
// ###################################################################
// LSU execute stage: data cache read and load data extension
// ###################################################################
`timescale 1ns/1ps

module lsu_ex (
    input  lsu_types_pkg::lsu_op_t i_op,
    input  lsu_types_pkg::data_t   i_dc_rdata,
    output logic                   o_dc_re,
    output lsu_types_pkg::addr_t   o_dc_raddr,
    output lsu_types_pkg::cdb_t    o_cdb
);

    logic                 is_load;
    lsu_types_pkg::data_t lane;
    lsu_types_pkg::data_t load_data;

    assign is_load = i_op.func inside {lsu_types_pkg::LB, lsu_types_pkg::LH, lsu_types_pkg::LW,
                                       lsu_types_pkg::LBU, lsu_types_pkg::LHU};

    assign o_dc_re    = i_op.valid && is_load;
    assign o_dc_raddr = {i_op.addr[lsu_cfg_pkg::XLEN-1:2], 2'b00};

    // Move the addressed byte or halfword down to lane 0
    assign lane = i_dc_rdata >> {i_op.addr[1:0], 3'b000};

    always_comb begin
        case (i_op.func)
            lsu_types_pkg::LB:  load_data = {{(lsu_cfg_pkg::XLEN-8){lane[7]}}, lane[7:0]};
            lsu_types_pkg::LH:  load_data = {{(lsu_cfg_pkg::XLEN-16){lane[15]}}, lane[15:0]};
            lsu_types_pkg::LBU: load_data = {{(lsu_cfg_pkg::XLEN-8){1'b0}}, lane[7:0]};
            lsu_types_pkg::LHU: load_data = {{(lsu_cfg_pkg::XLEN-16){1'b0}}, lane[15:0]};
            lsu_types_pkg::LW:  load_data = i_dc_rdata;
            default:            load_data = '0;
        endcase
    end

    // Stores only report their tag
    assign o_cdb = '{
        valid: i_op.valid,
        tag:   i_op.tag,
        data:  is_load ? load_data : '0
    };

    // A valid operation carries one of the eight defined functions
    always_comb begin
        if (i_op.valid) begin
            a_legal_func: assert (i_op.func inside {lsu_types_pkg::LB, lsu_types_pkg::LH,
                                                    lsu_types_pkg::LW, lsu_types_pkg::LBU,
                                                    lsu_types_pkg::LHU, lsu_types_pkg::SB,
                                                    lsu_types_pkg::SH, lsu_types_pkg::SW})
                else $error("lsu_ex: undefined access function");
        end
    end

endmodule

// ==== lsu_id.sv ====
// ###################################################################
// LSU decode stage: access function, effective address and
// load/store queue allocation
// ###################################################################
`timescale 1ns/1ps

module lsu_id (
    input  logic                     i_valid,
    input  lsu_types_pkg::data_t     i_insn,
    input  lsu_types_pkg::data_t     i_src_a,
    input  lsu_types_pkg::data_t     i_src_b,
    input  lsu_types_pkg::tag_t      i_tag,
    output lsu_types_pkg::lsu_op_t   o_op,
    output logic                     o_lq_alloc_en,
    output logic                     o_sq_alloc_en,
    output lsu_types_pkg::sq_alloc_t o_sq_alloc
);

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic                      op_load;
    logic                      op_store;
    lsu_types_pkg::data_t      imm_i;
    lsu_types_pkg::data_t      imm_s;
    lsu_types_pkg::addr_t      addr;
    lsu_types_pkg::lsu_func_t  func;

    assign opcode   = i_insn[6:0];
    assign funct3   = i_insn[14:12];
    assign op_load  = (opcode == lsu_types_pkg::OPC_LOAD);
    assign op_store = (opcode == lsu_types_pkg::OPC_STORE);

    // Sign extended immediates
    assign imm_i = {{(lsu_cfg_pkg::XLEN-12){i_insn[31]}}, i_insn[31:20]};
    assign imm_s = {{(lsu_cfg_pkg::XLEN-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]};

    assign addr = i_src_a + (op_store ? imm_s : imm_i);
    assign func = lsu_types_pkg::lsu_func_t'({op_store, funct3});

    assign o_op = '{
        func:  func,
        addr:  addr,
        tag:   i_tag,
        valid: i_valid && (op_load || op_store)
    };

    assign o_lq_alloc_en = i_valid && op_load;
    assign o_sq_alloc_en = i_valid && op_store;

    // Store data comes from rs2
    assign o_sq_alloc = '{func: func, addr: addr, data: i_src_b, tag: i_tag};

endmodule

// ==== lsu_lq.sv ====
// ###################################################################
// Load queue: word addresses of loads in flight, flagged when a
// retiring store writes the same word
// ###################################################################
`timescale 1ns/1ps

module lsu_lq (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,
    input  logic                 i_alloc_en,
    input  lsu_types_pkg::addr_t i_alloc_addr,
    input  lsu_types_pkg::tag_t  i_alloc_tag,
    input  logic                 i_st_en,
    input  lsu_types_pkg::addr_t i_st_addr,
    input  logic                 i_retire_en,
    input  lsu_types_pkg::tag_t  i_retire_tag,
    output logic                 o_mis_speculated,
    output logic                 o_full
);

    logic [lsu_cfg_pkg::LQ_DEPTH-1:0] lq_valid;
    logic [lsu_cfg_pkg::LQ_DEPTH-1:0] lq_flag;
    logic [lsu_cfg_pkg::LQ_DEPTH-1:0] alloc_sel;
    logic [lsu_cfg_pkg::LQ_DEPTH-1:0] retire_hit;
    logic [lsu_cfg_pkg::LQ_DEPTH-1:0] st_hit;
    lsu_types_pkg::tag_t              lq_tag  [lsu_cfg_pkg::LQ_DEPTH];
    lsu_types_pkg::addr_t             lq_addr [lsu_cfg_pkg::LQ_DEPTH];

    // Lowest clear bit of the valid vector
    assign alloc_sel = ~lq_valid & (lq_valid + 1'b1);

    always_comb begin
        for (int i = 0; i < lsu_cfg_pkg::LQ_DEPTH; i++) begin
            retire_hit[i] = lq_valid[i] && (lq_tag[i] == i_retire_tag);
            st_hit[i]     = lq_valid[i] &&
                            (lq_addr[i][lsu_cfg_pkg::XLEN-1:2] == i_st_addr[lsu_cfg_pkg::XLEN-1:2]);
        end
    end

    assign o_mis_speculated = i_retire_en && |(retire_hit & lq_flag);
    assign o_full           = &lq_valid;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            lq_valid <= '0;
            lq_flag  <= '0;
        end else if (i_flush) begin
            lq_valid <= '0;
            lq_flag  <= '0;
        end else begin
            for (int i = 0; i < lsu_cfg_pkg::LQ_DEPTH; i++) begin
                if (i_retire_en && retire_hit[i]) begin
                    lq_valid[i] <= 1'b0;
                end
                if (i_st_en && st_hit[i]) begin
                    lq_flag[i] <= 1'b1;
                end
                // A new load is younger than any retiring store
                if (i_alloc_en && alloc_sel[i]) begin
                    lq_valid[i] <= 1'b1;
                    lq_flag[i]  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < lsu_cfg_pkg::LQ_DEPTH; i++) begin
            if (i_alloc_en && alloc_sel[i]) begin
                lq_tag[i]  <= i_alloc_tag;
                lq_addr[i] <= {i_alloc_addr[lsu_cfg_pkg::XLEN-1:2], 2'b00};
            end
        end
    end

    // Top level must hold allocation off while full
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !o_full);

    // ROB retires only loads it handed to this unit
    a_retire_hits: assert property (@(posedge clk) disable iff (!n_rst)
        i_retire_en |-> $onehot(retire_hit));

endmodule

// ==== lsu_sq.sv ====
// ###################################################################
// Store queue: holds stores in order until retire, then writes
// them to the data cache with byte enables
// ###################################################################
`timescale 1ns/1ps

module lsu_sq (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     i_flush,
    input  logic                     i_alloc_en,
    input  lsu_types_pkg::sq_alloc_t i_alloc,
    input  logic                     i_retire_en,
    input  lsu_types_pkg::tag_t      i_retire_tag,
    input  logic                     i_dc_hit,
    input  logic                     i_msq_full,
    output logic                     o_wr_en,
    output lsu_types_pkg::addr_t     o_wr_addr,
    output lsu_types_pkg::byte_en_t  o_wr_byte_en,
    output lsu_types_pkg::data_t     o_wr_data,
    output logic                     o_retire_stall,
    output logic                     o_full
);

    lsu_types_pkg::sq_alloc_t         sq_mem [lsu_cfg_pkg::SQ_DEPTH];
    lsu_types_pkg::sq_alloc_t         head;
    logic [lsu_cfg_pkg::SQ_PTR_W-1:0] head_ptr;
    logic [lsu_cfg_pkg::SQ_PTR_W-1:0] tail_ptr;
    logic [lsu_cfg_pkg::SQ_PTR_W:0]   count;
    logic                             push;
    logic                             pop;
    lsu_types_pkg::byte_en_t          base_en;

    // Pointer increment with wrap for any depth
    function automatic logic [lsu_cfg_pkg::SQ_PTR_W-1:0] ptr_next(
        input logic [lsu_cfg_pkg::SQ_PTR_W-1:0] ptr
    );
        if (ptr == (lsu_cfg_pkg::SQ_PTR_W)'(lsu_cfg_pkg::SQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head   = sq_mem[head_ptr];
    assign push   = i_alloc_en;
    assign pop    = o_wr_en && i_dc_hit && !i_msq_full;
    assign o_full = (count == (lsu_cfg_pkg::SQ_PTR_W + 1)'(lsu_cfg_pkg::SQ_DEPTH));

    // Head entry is offered for as long as the ROB holds retire
    assign o_wr_en        = i_retire_en;
    assign o_retire_stall = i_retire_en && !pop;

    always_comb begin
        case (head.func)
            lsu_types_pkg::SB: base_en = 4'b0001;
            lsu_types_pkg::SH: base_en = 4'b0011;
            default:           base_en = 4'b1111;
        endcase
    end

    // Byte enables and data moved to the addressed lanes
    assign o_wr_byte_en = base_en << head.addr[1:0];
    assign o_wr_data    = head.data << {head.addr[1:0], 3'b000};
    assign o_wr_addr    = {head.addr[lsu_cfg_pkg::XLEN-1:2], 2'b00};

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (i_flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= ptr_next(tail_ptr);
            end
            if (pop) begin
                head_ptr <= ptr_next(head_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            sq_mem[tail_ptr] <= i_alloc;
        end
    end

    // Stores retire in program order, so the ROB tag is the head's
    a_retire_head: assert property (@(posedge clk) disable iff (!n_rst)
        i_retire_en |-> (count != '0) && (i_retire_tag == head.tag));

endmodule

// ==== lsu_types_pkg.sv ====
// ###################################################################
// LSU types: width typedefs, access function and stage words
// ###################################################################
package lsu_types_pkg;

    typedef logic [lsu_cfg_pkg::XLEN-1:0]   data_t;
    typedef logic [lsu_cfg_pkg::XLEN-1:0]   addr_t;
    typedef logic [lsu_cfg_pkg::TAG_W-1:0]  tag_t;
    typedef logic [lsu_cfg_pkg::XLEN/8-1:0] byte_en_t;

    // Low three bits are funct3, bit 3 marks a store
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_func_t;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    typedef struct packed {
        lsu_func_t func;
        addr_t     addr;
        tag_t      tag;
        logic      valid;
    } lsu_op_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } cdb_t;

    typedef struct packed {
        lsu_func_t func;
        addr_t     addr;
        data_t     data;
        tag_t      tag;
    } sq_alloc_t;

endpackage

// ==== tb_lsu.sv ====
// ###################################################################
// LSU testbench: random loads and stores against a read-only cache
// model, with assertions on the CDB, store retire and queue status
// ###################################################################
`timescale 1ns/1ps

module tb_lsu;

    localparam int WAIT_LIMIT = 50;

    logic                    clk;
    logic                    n_rst;
    logic                    i_flush;
    logic                    i_fu_valid;
    lsu_types_pkg::data_t    i_fu_insn;
    lsu_types_pkg::data_t    i_fu_src_a;
    lsu_types_pkg::data_t    i_fu_src_b;
    lsu_types_pkg::tag_t     i_fu_tag;
    logic                    o_fu_stall;
    logic                    o_cdb_en;
    lsu_types_pkg::tag_t     o_cdb_tag;
    lsu_types_pkg::data_t    o_cdb_data;
    lsu_types_pkg::tag_t     i_rob_retire_tag;
    logic                    i_rob_retire_lq_en;
    logic                    i_rob_retire_sq_en;
    logic                    o_rob_retire_stall;
    logic                    o_rob_retire_mis_speculated;
    lsu_types_pkg::data_t    i_dc_rdata;
    logic                    o_dc_re;
    lsu_types_pkg::addr_t    o_dc_raddr;
    logic                    i_sq_retire_dc_hit;
    logic                    i_sq_retire_msq_full;
    logic                    o_sq_retire_en;
    lsu_types_pkg::byte_en_t o_sq_retire_byte_en;
    lsu_types_pkg::addr_t    o_sq_retire_addr;
    lsu_types_pkg::data_t    o_sq_retire_data;

    // Operation currently presented, as the reference model sees it
    logic                    drv_store;
    logic [2:0]              drv_f3;
    lsu_types_pkg::addr_t    drv_addr;
    lsu_types_pkg::data_t    drv_data;

    // Expected CDB words, one per register stage
    logic                    e1_v;
    logic                    e2_v;
    logic                    e1_ld;
    lsu_types_pkg::addr_t    e1_raddr;
    lsu_types_pkg::tag_t     e1_tag;
    lsu_types_pkg::tag_t     e2_tag;
    lsu_types_pkg::data_t    e1_data;
    lsu_types_pkg::data_t    e2_data;

    logic [63:0]             ld_live;
    logic [63:0]             ld_flag;
    logic [29:0]             ld_word [64];
    lsu_types_pkg::addr_t    sq_addr [8];
    lsu_types_pkg::byte_en_t sq_be [8];
    lsu_types_pkg::data_t    sq_lanes [8];
    int                      lq_cnt;
    int                      sq_cnt;
    int                      sq_rd;
    int                      sq_wr;
    logic                    accept;
    logic                    st_write;
    logic                    exp_stall;
    logic                    exp_mis;
    lsu_types_pkg::tag_t     next_tag;
    int                      check_errs;
    int                      timeouts;

    lsu u_dut (.*);

    always #20 clk = ~clk;

    // Fixed contents that differ for every word address
    function automatic lsu_types_pkg::data_t mem_word(input lsu_types_pkg::addr_t a);
        return ({a[31:2], 2'b01} * 32'h9e3779b1) ^ 32'h5a5ac3c3;
    endfunction

    function automatic lsu_types_pkg::data_t load_result(input logic [2:0] f3,
                                                         input lsu_types_pkg::data_t word,
                                                         input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (f3)
            3'd0:    return {{24{b[7]}}, b};
            3'd1:    return {{16{h[15]}}, h};
            3'd4:    return {24'd0, b};
            3'd5:    return {16'd0, h};
            default: return word;
        endcase
    endfunction

    function automatic lsu_types_pkg::byte_en_t store_be(input logic [2:0] f3,
                                                         input logic [1:0] off);
        case (f3)
            3'd0:    return 4'b0001 << off;
            3'd1:    return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic lsu_types_pkg::data_t store_lanes(input logic [2:0] f3,
                                                         input logic [1:0] off,
                                                         input lsu_types_pkg::data_t d);
        lsu_types_pkg::data_t lanes;
        lanes = '0;
        case (f3)
            3'd0:    lanes[8*off +: 8] = d[7:0];
            3'd1:    lanes[16*off[1] +: 16] = d[15:0];
            default: lanes = d;
        endcase
        return lanes;
    endfunction

    function automatic lsu_types_pkg::data_t byte_mask(input lsu_types_pkg::byte_en_t be);
        lsu_types_pkg::data_t m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    assign i_dc_rdata = mem_word(o_dc_raddr);
    assign exp_stall  = (lq_cnt == lsu_cfg_pkg::LQ_DEPTH) || (sq_cnt == lsu_cfg_pkg::SQ_DEPTH);
    assign accept     = i_fu_valid && !exp_stall;
    assign st_write   = i_rob_retire_sq_en && i_sq_retire_dc_hit && !i_sq_retire_msq_full;
    assign exp_mis    = ld_flag[i_rob_retire_tag];

    // Reference model of the pipeline and both queues
    always @(posedge clk or negedge n_rst) begin
        if (!n_rst || i_flush) begin
            e1_v    <= 1'b0;
            e2_v    <= 1'b0;
            e1_ld   <= 1'b0;
            ld_live <= '0;
            ld_flag <= '0;
            lq_cnt  <= 0;
            sq_cnt  <= 0;
            sq_rd   <= 0;
            sq_wr   <= 0;
        end else begin
            e2_v     <= e1_v;
            e2_tag   <= e1_tag;
            e2_data  <= e1_data;
            e1_v     <= accept;
            e1_ld    <= accept && !drv_store;
            e1_raddr <= {drv_addr[31:2], 2'b00};
            e1_tag   <= i_fu_tag;
            e1_data  <= drv_store ? '0 : load_result(drv_f3, mem_word(drv_addr), drv_addr[1:0]);
            if (st_write) begin
                for (int t = 0; t < 64; t++) begin
                    if (ld_live[t] && ld_word[t] == sq_addr[sq_rd][31:2]) begin
                        ld_flag[t] <= 1'b1;
                    end
                end
                sq_rd <= (sq_rd + 1) % 8;
            end
            if (i_rob_retire_lq_en) begin
                ld_live[i_rob_retire_tag] <= 1'b0;
            end
            if (accept && !drv_store) begin
                ld_live[i_fu_tag] <= 1'b1;
                ld_flag[i_fu_tag] <= 1'b0;
                ld_word[i_fu_tag] <= drv_addr[31:2];
            end
            if (accept && drv_store) begin
                sq_addr[sq_wr]  <= {drv_addr[31:2], 2'b00};
                sq_be[sq_wr]    <= store_be(drv_f3, drv_addr[1:0]);
                sq_lanes[sq_wr] <= store_lanes(drv_f3, drv_addr[1:0], drv_data);
                sq_wr           <= (sq_wr + 1) % 8;
            end
            lq_cnt <= lq_cnt + int'(accept && !drv_store) - int'(i_rob_retire_lq_en);
            sq_cnt <= sq_cnt + int'(accept && drv_store) - int'(st_write);
        end
    end

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        check_errs++;
        $display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
    endtask

    task automatic report_text(input string what);
        check_errs++;
        $display("Check failed at %0t: %s", $time, what);
    endtask

    a_reset_idle: assert property (@(posedge clk) !n_rst |->
        !(o_cdb_en || o_dc_re || o_sq_retire_en || o_fu_stall || o_rob_retire_stall))
        else report_text("an output is active during reset");
    a_cdb_en: assert property (@(posedge clk) disable iff (!n_rst) o_cdb_en == e2_v)
        else report_value("o_cdb_en", $sampled(o_cdb_en), $sampled(e2_v));
    a_cdb_tag: assert property (@(posedge clk) disable iff (!n_rst)
        o_cdb_en |-> o_cdb_tag == e2_tag)
        else report_value("o_cdb_tag", $sampled(o_cdb_tag), $sampled(e2_tag));
    a_cdb_data: assert property (@(posedge clk) disable iff (!n_rst)
        o_cdb_en |-> o_cdb_data == e2_data)
        else report_value("o_cdb_data", $sampled(o_cdb_data), $sampled(e2_data));
    a_dc_re: assert property (@(posedge clk) disable iff (!n_rst) o_dc_re == e1_ld)
        else report_value("o_dc_re", $sampled(o_dc_re), $sampled(e1_ld));
    a_dc_raddr: assert property (@(posedge clk) disable iff (!n_rst)
        o_dc_re |-> o_dc_raddr == e1_raddr)
        else report_value("o_dc_raddr", $sampled(o_dc_raddr), $sampled(e1_raddr));
    a_sq_en: assert property (@(posedge clk) disable iff (!n_rst)
        o_sq_retire_en == i_rob_retire_sq_en)
        else report_value("o_sq_retire_en", $sampled(o_sq_retire_en), $sampled(i_rob_retire_sq_en));
    a_sq_addr: assert property (@(posedge clk) disable iff (!n_rst)
        o_sq_retire_en |-> o_sq_retire_addr == sq_addr[sq_rd])
        else report_value("o_sq_retire_addr", $sampled(o_sq_retire_addr), $sampled(sq_addr[sq_rd]));
    a_sq_be: assert property (@(posedge clk) disable iff (!n_rst)
        o_sq_retire_en |-> o_sq_retire_byte_en == sq_be[sq_rd])
        else report_value("o_sq_retire_byte_en", $sampled(o_sq_retire_byte_en),
                          $sampled(sq_be[sq_rd]));
    // Only the enabled lanes carry store data
    a_sq_data: assert property (@(posedge clk) disable iff (!n_rst)
        o_sq_retire_en |-> (o_sq_retire_data & byte_mask(sq_be[sq_rd])) == sq_lanes[sq_rd])
        else report_value("o_sq_retire_data", $sampled(o_sq_retire_data),
                          $sampled(sq_lanes[sq_rd]));
    a_ret_stall: assert property (@(posedge clk) disable iff (!n_rst)
        o_rob_retire_stall == (i_rob_retire_sq_en && !st_write))
        else report_value("o_rob_retire_stall", $sampled(o_rob_retire_stall),
                          $sampled(i_rob_retire_sq_en && !st_write));
    a_mis_spec: assert property (@(posedge clk) disable iff (!n_rst)
        i_rob_retire_lq_en |-> o_rob_retire_mis_speculated == exp_mis)
        else report_value("o_rob_retire_mis_speculated", $sampled(o_rob_retire_mis_speculated),
                          $sampled(exp_mis));
    a_fu_stall: assert property (@(posedge clk) disable iff (!n_rst) o_fu_stall == exp_stall)
        else report_value("o_fu_stall", $sampled(o_fu_stall), $sampled(exp_stall));

    // Loads pick any width, stores SB/SH/SW, offsets kept aligned
    task automatic present_random(input logic store, input int word,
                                  output lsu_types_pkg::tag_t tag);
        logic [2:0]  f3;
        logic [1:0]  off;
        logic [11:0] imm;
        f3 = store ? 3'($urandom_range(2)) : 3'($urandom_range(4));
        if (!store && f3 == 3'd3) begin
            f3 = 3'd5;
        end
        off = 2'($urandom);
        if (f3[1:0] == 2'd1) begin
            off[0] = 1'b0;
        end
        if (f3[1:0] == 2'd2) begin
            off = 2'd0;
        end
        imm        = 12'($urandom);
        tag        = next_tag;
        next_tag   = next_tag + 1'b1;
        drv_store  = store;
        drv_f3     = f3;
        drv_addr   = 32'h0000_4000 + 32'(word * 4) + 32'(off);
        drv_data   = $urandom;
        i_fu_src_a = drv_addr - {{20{imm[11]}}, imm};
        i_fu_src_b = drv_data;
        i_fu_tag   = tag;
        if (store) begin
            i_fu_insn = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], lsu_types_pkg::OPC_STORE};
        end else begin
            i_fu_insn = {imm, 5'd1, f3, 5'd3, lsu_types_pkg::OPC_LOAD};
        end
        i_fu_valid = 1'b1;
    endtask

    // Stall only changes at a rising edge, so its value here holds for the next one
    task automatic wait_accept();
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            done = !o_fu_stall;
            @(negedge clk);
            waited++;
        end
        i_fu_valid = 1'b0;
        if (!done) begin
            timeouts++;
            $display("Timeout: operation with tag %0d was never accepted", i_fu_tag);
        end
    endtask

    task automatic issue_random(input logic store, input int word,
                                output lsu_types_pkg::tag_t tag);
        present_random(store, word, tag);
        wait_accept();
    endtask

    task automatic retire_load(input lsu_types_pkg::tag_t tag);
        i_rob_retire_lq_en = 1'b1;
        i_rob_retire_tag   = tag;
        @(negedge clk);
        i_rob_retire_lq_en = 1'b0;
    endtask

    // Cache port stays busy for the given number of cycles
    task automatic retire_store(input lsu_types_pkg::tag_t tag, input int busy);
        int   waited;
        logic done;
        i_rob_retire_sq_en   = 1'b1;
        i_rob_retire_tag     = tag;
        i_sq_retire_dc_hit   = 1'b1;
        i_sq_retire_msq_full = (busy > 0);
        waited = 0;
        done   = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            @(posedge clk);
            done = !o_rob_retire_stall;
            @(negedge clk);
            waited++;
            if (waited >= busy) begin
                i_sq_retire_msq_full = 1'b0;
            end
        end
        i_rob_retire_sq_en = 1'b0;
        if (!done) begin
            timeouts++;
            $display("Timeout: store with tag %0d was never written", tag);
        end
    endtask

    initial begin
        lsu_types_pkg::tag_t tags [$];
        lsu_types_pkg::tag_t t;
        lsu_types_pkg::tag_t ld_near;
        lsu_types_pkg::tag_t ld_far;
        void'($urandom(32'hfacbab05));
        clk                  = 1'b0;
        n_rst                = 1'b0;
        i_flush              = 1'b0;
        i_fu_valid           = 1'b0;
        i_fu_insn            = '0;
        i_fu_src_a           = '0;
        i_fu_src_b           = '0;
        i_fu_tag             = '0;
        i_rob_retire_tag     = '0;
        i_rob_retire_lq_en   = 1'b0;
        i_rob_retire_sq_en   = 1'b0;
        i_sq_retire_dc_hit   = 1'b0;
        i_sq_retire_msq_full = 1'b0;
        drv_store            = 1'b0;
        drv_f3               = 3'd2;
        drv_addr             = '0;
        drv_data             = '0;
        next_tag             = '0;
        check_errs           = 0;
        timeouts             = 0;
        repeat (5) @(negedge clk);
        n_rst = 1'b1;

        // Random loads, four at a time
        for (int g = 0; g < 4; g++) begin
            for (int i = 0; i < 4; i++) begin
                issue_random(1'b0, $urandom_range(7), t);
                tags.push_back(t);
            end
            while (tags.size() > 0) begin
                retire_load(tags.pop_front());
            end
        end

        // Older loads, then stores; the first store hits ld_near's word
        issue_random(1'b0, 0, ld_near);
        issue_random(1'b0, 5, ld_far);
        for (int i = 0; i < 3; i++) begin
            issue_random(1'b1, (i == 0) ? 0 : i + 1, t);
            tags.push_back(t);
        end
        retire_store(tags.pop_front(), 3);
        while (tags.size() > 0) begin
            retire_store(tags.pop_front(), $urandom_range(1));
        end
        retire_load(ld_near);
        retire_load(ld_far);

        // Fifth load is held until a retire frees a slot
        for (int i = 0; i < 4; i++) begin
            issue_random(1'b0, i, t);
            tags.push_back(t);
        end
        present_random(1'b0, 6, t);
        repeat (3) @(negedge clk);
        retire_load(tags.pop_front());
        wait_accept();
        tags.push_back(t);
        while (tags.size() > 0) begin
            retire_load(tags.pop_front());
        end

        // Flush with both queues occupied
        issue_random(1'b1, 2, t);
        issue_random(1'b1, 3, t);
        for (int i = 0; i < 4; i++) begin
            issue_random(1'b0, i, t);
        end
        i_flush = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
        issue_random(1'b0, 1, t);
        retire_load(t);
        issue_random(1'b1, 4, t);
        retire_store(t, 0);
        repeat (4) @(negedge clk);

        $display("Checks failed: %0d, timeouts: %0d", check_errs, timeouts);
        if (check_errs == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
